// ==== verilog/pdu_config.svh ====
`ifndef PDU_CONFIG_SVH
`define PDU_CONFIG_SVH

// One matcher per keyword
`define PDU_NUM_CMDS 6

// Program window a run may stay inside
`define PDU_PC_MIN 32'h3000
`define PDU_PC_MAX 32'h3fff

// clk cycles per cpu_clk phase
`define PDU_CPU_CLK_HALF 4

// Width of addresses, program counters and hex arguments
`define PDU_ARG_W 32

`endif

// ==== verilog/pdu_pkg.sv ====
`default_nettype none

`include "pdu_config.svh"

package pdu_pkg;

    typedef logic [`PDU_ARG_W-1:0] word_t;
    typedef logic [7:0] byte_t;
    typedef logic [3:0] nibble_t;

    // Index equals matcher instance number
    typedef enum logic [2:0] {
        CMD_RUN,
        CMD_STEP,
        CMD_BP,
        CMD_CK,
        CMD_ADD,
        CMD_SUB
    } cmd_e;

    typedef struct packed {
        logic  hit;
        word_t arg;
    } cmd_hit_t;

    localparam int MAX_KEY_LEN = 5;

    // Unused tail characters are zero
    localparam byte_t KEYWORDS [`PDU_NUM_CMDS][MAX_KEY_LEN] = '{
        '{"r", "u", "n", ";", 8'h00},
        '{"s", "t", "e", "p", ";"},
        '{"b", "p", " ", 8'h00, 8'h00},
        '{"c", "k", " ", 8'h00, 8'h00},
        '{"a", "d", "d", ";", 8'h00},
        '{"s", "u", "b", ";", 8'h00}
    };

    localparam int KEY_LEN [`PDU_NUM_CMDS] = '{4, 5, 3, 3, 4, 4};

    localparam bit TAKES_ARG [`PDU_NUM_CMDS] = '{0, 0, 1, 1, 0, 0};

endpackage

`default_nettype wire

// ==== verilog/cmd_byte_if.sv ====
`default_nettype none

interface cmd_byte_if;

    logic             vld;
    pdu_pkg::byte_t   data;
    logic             is_hex;
    pdu_pkg::nibble_t hex_val;
    logic             is_term;

    modport intake (
        output vld, data, is_hex, hex_val, is_term
    );

    // Every keyword matcher sees the same stream
    modport matcher (
        input vld, data, is_hex, hex_val, is_term
    );

endinterface

`default_nettype wire

// ==== verilog/byte_intake.sv ====
`default_nettype none

module byte_intake (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 din_vld,
    input  wire pdu_pkg::byte_t din_data,
    input  wire                 busy,
    cmd_byte_if.intake          bus
);

    logic             hex_ok;
    pdu_pkg::nibble_t hex_nib;

    // Lower case hex digits only
    always_comb begin
        hex_ok  = 1'b0;
        hex_nib = '0;
        if (din_data >= "0" && din_data <= "9") begin
            hex_ok  = 1'b1;
            hex_nib = 4'(din_data - "0");
        end else if (din_data >= "a" && din_data <= "f") begin
            hex_ok  = 1'b1;
            hex_nib = 4'(din_data - "a" + 8'd10);
        end
    end

    // Bytes typed during a run are lost
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.vld <= 1'b0;
        end else begin
            bus.vld <= din_vld && !busy;
        end
    end

    always_ff @(posedge clk) begin
        bus.data    <= din_data;
        bus.is_hex  <= hex_ok;
        bus.hex_val <= hex_nib;
        bus.is_term <= (din_data == ";");
    end

endmodule

`default_nettype wire

// ==== verilog/cmd_matcher.sv ====
`default_nettype none

`include "pdu_config.svh"

module cmd_matcher #(
    parameter pdu_pkg::cmd_e cmd = pdu_pkg::CMD_RUN
) (
    input  wire                    clk,
    input  wire                    rst,
    cmd_byte_if.matcher            bus,
    output pdu_pkg::cmd_hit_t      result
);

    localparam int  KEY_LAST = pdu_pkg::KEY_LEN[cmd] - 1;
    localparam bit  HAS_ARG  = pdu_pkg::TAKES_ARG[cmd];
    localparam int  POS_W    = $clog2(pdu_pkg::MAX_KEY_LEN);

    logic [POS_W-1:0] pos;
    logic             in_arg;
    logic             hit;
    pdu_pkg::word_t   arg;
    logic             take;
    logic             last;
    logic             restart;

    assign take    = (bus.data == pdu_pkg::KEYWORDS[cmd][pos]);
    assign last    = (int'(pos) == KEY_LAST);
    assign restart = (bus.data == pdu_pkg::KEYWORDS[cmd][0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            pos    <= '0;
            in_arg <= 1'b0;
            hit    <= 1'b0;
        end else begin
            hit <= 1'b0;
            if (bus.vld) begin
                if (in_arg) begin
                    // Terminator closes the argument and junk abandons it
                    if (bus.is_term) begin
                        hit    <= 1'b1;
                        in_arg <= 1'b0;
                    end else if (!bus.is_hex) begin
                        in_arg <= 1'b0;
                    end
                end else if (take) begin
                    if (last) begin
                        pos <= '0;
                        if (HAS_ARG) begin
                            in_arg <= 1'b1;
                        end else begin
                            hit <= 1'b1;
                        end
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end else if (restart) begin
                    pos <= POS_W'(1);
                end else begin
                    pos <= '0;
                end
            end
        end
    end

    // Hex digits enter at the low end
    always_ff @(posedge clk) begin
        if (bus.vld && !in_arg && take && last) begin
            arg <= '0;
        end else if (bus.vld && in_arg && bus.is_hex) begin
            arg <= {arg[`PDU_ARG_W-5:0], bus.hex_val};
        end
    end

    assign result.hit = hit;
    assign result.arg = arg;

endmodule

`default_nettype wire

// ==== verilog/cpu_clk_gen.sv ====
`default_nettype none

`include "pdu_config.svh"

module cpu_clk_gen (
    input  wire  clk,
    input  wire  rst,
    input  wire  clk_en,
    output logic cpu_clk
);

    localparam int PERIOD = 2 * `PDU_CPU_CLK_HALF;
    localparam int CNT_W  = $clog2(PERIOD);

    localparam logic [CNT_W-1:0] FALL_CNT = CNT_W'(`PDU_CPU_CLK_HALF);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(PERIOD - 1);

    // Zero means idle
    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            cpu_clk <= 1'b0;
        end else if (cnt == '0) begin
            if (clk_en) begin
                cnt     <= CNT_W'(1);
                cpu_clk <= 1'b1;
            end
        end else begin
            // Runs to the end even if clk_en drops
            if (cnt == FALL_CNT) begin
                cpu_clk <= 1'b0;
            end
            if (cnt == LAST_CNT) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/debug_sequencer.sv ====
`default_nettype none

`include "pdu_config.svh"

module debug_sequencer (
    input  wire                    clk,
    input  wire                    rst,
    input  wire pdu_pkg::cmd_hit_t hits [`PDU_NUM_CMDS],
    input  wire pdu_pkg::word_t    current_pc,
    input  wire pdu_pkg::word_t    next_pc,
    output pdu_pkg::word_t         check_addr,
    output pdu_pkg::word_t         bp_pc,
    output logic                   busy,
    output logic                   clk_en,
    output logic                   running
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_STEP_LOAD,
        S_RUN
    } state_e;

    state_e state;
    logic   stop;

    // Breakpoint reached or PC outside the program window
    assign stop = (current_pc == bp_pc)
               || (current_pc < `PDU_PC_MIN)
               || (current_pc > `PDU_PC_MAX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            clk_en     <= 1'b0;
            check_addr <= '0;
            bp_pc      <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (hits[pdu_pkg::CMD_RUN].hit) begin
                        state  <= S_RUN;
                        clk_en <= 1'b1;
                    end else if (hits[pdu_pkg::CMD_STEP].hit) begin
                        // Stop after one instruction
                        bp_pc <= next_pc;
                        state <= S_STEP_LOAD;
                    end else if (hits[pdu_pkg::CMD_BP].hit) begin
                        bp_pc <= hits[pdu_pkg::CMD_BP].arg;
                    end else if (hits[pdu_pkg::CMD_CK].hit) begin
                        check_addr <= hits[pdu_pkg::CMD_CK].arg;
                    end else if (hits[pdu_pkg::CMD_ADD].hit) begin
                        check_addr <= check_addr + 1'b1;
                    end else if (hits[pdu_pkg::CMD_SUB].hit) begin
                        check_addr <= check_addr - 1'b1;
                    end
                end
                S_STEP_LOAD: begin
                    state  <= S_RUN;
                    clk_en <= 1'b1;
                end
                S_RUN: begin
                    if (stop) begin
                        state  <= S_IDLE;
                        clk_en <= 1'b0;
                    end
                end
                default: begin
                    state  <= S_IDLE;
                    clk_en <= 1'b0;
                end
            endcase
        end
    end

    assign running = (state == S_RUN);

    // Intake drops bytes for the whole run
    assign busy = running;

endmodule

`default_nettype wire

// ==== verilog/pdu_ctrl.sv ====
`default_nettype none

`include "pdu_config.svh"

module pdu_ctrl (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 din_vld,
    input  wire pdu_pkg::byte_t din_data,
    input  wire pdu_pkg::word_t current_pc,
    input  wire pdu_pkg::word_t next_pc,
    output pdu_pkg::word_t      check_addr,
    output pdu_pkg::word_t      bp_pc,
    output logic                cpu_clk,
    output logic                running
);

    cmd_byte_if        cmd_bus ();
    pdu_pkg::cmd_hit_t hits [`PDU_NUM_CMDS];
    logic              busy;
    logic              clk_en;

    byte_intake u_intake (
        .clk      (clk),
        .rst      (rst),
        .din_vld  (din_vld),
        .din_data (din_data),
        .busy     (busy),
        .bus      (cmd_bus.intake)
    );

    // One matcher per command, in cmd_e order
    for (genvar i = 0; i < `PDU_NUM_CMDS; i++) begin : g_match
        cmd_matcher #(
            .cmd (pdu_pkg::cmd_e'(i))
        ) u_match (
            .clk    (clk),
            .rst    (rst),
            .bus    (cmd_bus.matcher),
            .result (hits[i])
        );
    end

    debug_sequencer u_seq (
        .clk        (clk),
        .rst        (rst),
        .hits       (hits),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .check_addr (check_addr),
        .bp_pc      (bp_pc),
        .busy       (busy),
        .clk_en     (clk_en),
        .running    (running)
    );

    cpu_clk_gen u_clk_gen (
        .clk     (clk),
        .rst     (rst),
        .clk_en  (clk_en),
        .cpu_clk (cpu_clk)
    );

endmodule

`default_nettype wire

// ==== tb/pdu_ctrl_assertions.sv ====
`default_nettype none

`include "pdu_config.svh"

module pdu_ctrl_assertions (
    input  wire                    clk,
    input  wire                    rst,
    input  wire pdu_pkg::cmd_hit_t hits [`PDU_NUM_CMDS],
    input  wire                    running,
    input  wire                    clk_en,
    input  wire                    stop
);

    timeunit 1ns;
    timeprecision 1ps;

    logic any_hit;

    always_comb begin
        any_hit = 1'b0;
        for (int i = 0; i < `PDU_NUM_CMDS; i++) begin
            any_hit = any_hit | hits[i].hit;
        end
    end

    // Intake drops bytes during a run, so no matcher fires
    hit_while_running: assert property (
        @(posedge clk) disable iff (rst) running |-> !any_hit
    ) else $error("command hit arrived while the CPU was running");

    // Breakpoint or window exit seen one cycle before the fall
    fall_needs_stop: assert property (
        @(posedge clk) disable iff (rst) $fell(running) |-> $past(stop)
    ) else $error("run ended without a stop condition");

    clk_en_only_in_run: assert property (
        @(posedge clk) disable iff (rst) !running |-> !clk_en
    ) else $error("CPU clock enabled outside a run");

endmodule

`default_nettype wire

// ==== tb/pdu_ctrl_tb.sv ====
`default_nettype none

module pdu_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string TEST_FILE     = "tb/pdu_tests.txt";
    localparam int    CYCLES_PER_OP = 200;
    // Host ';' strobe to register update plus one spare cycle
    localparam int    PIPE_CYCLES   = 4;

    logic           clk;
    logic           rst;
    logic           din_vld;
    pdu_pkg::byte_t din_data;
    pdu_pkg::word_t current_pc;
    pdu_pkg::word_t next_pc;
    pdu_pkg::word_t check_addr;
    pdu_pkg::word_t bp_pc;
    logic           cpu_clk;
    logic           running;

    // CPU model state
    pdu_pkg::word_t model_pc     = '0;
    logic           pc_load;
    pdu_pkg::word_t pc_load_val;
    logic           cpu_clk_q    = 1'b0;
    logic           running_q    = 1'b0;
    int             pulses_total = 0;
    int             runs_done    = 0;
    int             pulses_mark  = 0;
    int             runs_mark    = 0;

    int             cycles       = 0;
    int             cycle_limit  = 0;
    string          lines [$];

    pdu_ctrl uut (
        .clk        (clk),
        .rst        (rst),
        .din_vld    (din_vld),
        .din_data   (din_data),
        .current_pc (current_pc),
        .next_pc    (next_pc),
        .check_addr (check_addr),
        .bp_pc      (bp_pc),
        .cpu_clk    (cpu_clk),
        .running    (running)
    );

    bind debug_sequencer pdu_ctrl_assertions u_seq_assert (
        .clk     (clk),
        .rst     (rst),
        .hits    (hits),
        .running (running),
        .clk_en  (clk_en),
        .stop    (stop)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign current_pc = model_pc;
    assign next_pc    = model_pc + 32'd4;

    // PC advances by one instruction on each cpu_clk rise
    always @(posedge clk) begin
        cpu_clk_q <= cpu_clk;
        running_q <= running;
        if (pc_load) begin
            model_pc <= pc_load_val;
        end else if (cpu_clk && !cpu_clk_q) begin
            model_pc <= model_pc + 32'd4;
        end
        if (cpu_clk && !cpu_clk_q) begin
            pulses_total <= pulses_total + 1;
        end
        if (running_q && !running) begin
            runs_done <= runs_done + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_now($sformatf("Timeout: the tests did not finish within %0d cycles", cycles));
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input pdu_pkg::word_t got,
                              input pdu_pkg::word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic string trim_eol(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r[r.len()-1] == "\n" || r[r.len()-1] == "\r")) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    // One byte every other cycle
    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            @(negedge clk);
            // Text is only typed while the CPU is halted
            check_bit("running", running, 1'b0);
            @(posedge clk);
            din_vld  <= 1'b1;
            din_data <= text[i];
            @(posedge clk);
            din_vld  <= 1'b0;
        end
        repeat (PIPE_CYCLES) @(posedge clk);
    endtask

    task automatic set_pc(input pdu_pkg::word_t pc);
        @(posedge clk);
        pc_load     <= 1'b1;
        pc_load_val <= pc;
        @(posedge clk);
        pc_load     <= 1'b0;
    endtask

    task automatic wait_run_end(input pdu_pkg::word_t exp_pc, input int exp_pulses);
        while (runs_done == runs_mark) begin
            @(negedge clk);
        end
        runs_mark = runs_done;
        @(negedge clk);
        check_word("model_pc", model_pc, exp_pc);
        check_count("cpu_clk pulses", pulses_total - pulses_mark, exp_pulses);
        pulses_mark = pulses_total;
    endtask

    initial begin
        int             fd;
        int             got;
        int             num;
        string          line;
        byte            op;
        pdu_pkg::word_t val;

        rst         = 1'b1;
        din_vld     = 1'b0;
        din_data    = '0;
        pc_load     = 1'b0;
        pc_load_val = '0;

        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            fail_now({"Could not open the test file ", TEST_FILE});
        end
        while (!$feof(fd)) begin
            line = "";
            got  = $fgets(line, fd);
            if (got > 0) begin
                lines.push_back(trim_eol(line));
            end
        end
        $fclose(fd);
        cycle_limit = CYCLES_PER_OP * lines.size();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        foreach (lines[i]) begin
            line = lines[i];
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            op = line[0];
            if (op == "T") begin
                send_text(line.substr(2, line.len() - 1));
            end else if (op == "W") begin
                if ($sscanf(line, "%c %h %d", op, val, num) != 3) begin
                    fail_now({"The test file has a malformed wait line: ", line});
                end
                wait_run_end(val, num);
            end else begin
                if ($sscanf(line, "%c %h", op, val) != 2) begin
                    fail_now({"The test file has a malformed line: ", line});
                end
                case (op)
                    "A": begin
                        @(negedge clk);
                        check_word("check_addr", check_addr, val);
                    end
                    "B": begin
                        @(negedge clk);
                        check_word("bp_pc", bp_pc, val);
                    end
                    "P": begin
                        set_pc(val);
                    end
                    default: begin
                        fail_now({"The test file has an unknown operation: ", line});
                    end
                endcase
            end
        end

        repeat (PIPE_CYCLES) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/pdu_tests.txt ====
# T text: send bytes | A hex: expect check_addr | B hex: expect bp_pc
# P hex: set model PC | W hex n: wait for run end, expect model PC and pulse count
A 0
B 0
# Inspection address
T ck 2f3a;
A 2f3a
T add;add;sub;
A 2f3b
# Breakpoint load and a broken argument
T bp 3010;
B 3010
T bp 3g;
B 3010
A 2f3b
# Run to the breakpoint
P 3000
T run;
W 3010 4
# Single step
T step;
W 3014 1
B 3014
# Leaving the program window
T bp 0;
B 0
P 3ff8
T run;
W 4000 2
# Misspelled keyword
P 3000
T bp 3008;
B 3008
T rux;
A 2f3b
B 3008
T run;
W 3008 2
A 2f3b

// ==== sim.f ====
+incdir+verilog
verilog/pdu_pkg.sv
verilog/cmd_byte_if.sv
verilog/byte_intake.sv
verilog/cmd_matcher.sv
verilog/cpu_clk_gen.sv
verilog/debug_sequencer.sv
verilog/pdu_ctrl.sv
tb/pdu_ctrl_assertions.sv
tb/pdu_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pdu_ctrl_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
